/* build.f */
+incdir+rtl
rtl/CoreDefs.sv
rtl/InstDecoder.sv
rtl/Alu.sv
rtl/CsrUnit.sv
rtl/StageEX.sv
rtl/ResultStage.sv
rtl/ExecCore.sv
tests/ExecCoreTb.sv

/* rtl/Alu.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module Alu
    import CoreDefs::*;
(
    input  AluOp i_op,          // Operation
    input  Data  i_dataA,       // Operand A
    input  Data  i_dataB,       // Operand B
    output Data  o_result);     // Result

    localparam int ShamtWidth = $clog2(`DATA_WIDTH);

    logic [ShamtWidth-1:0] shamt;   // Low bits of B only
    logic                  ltSigned;
    logic                  ltUnsigned;

    assign shamt      = i_dataB[ShamtWidth-1:0];
    assign ltSigned   = $signed(i_dataA) < $signed(i_dataB);
    assign ltUnsigned = i_dataA < i_dataB;

    // --------------------
    // Operation select
    // --------------------
    always_comb begin
        case (i_op)
            AluOp_ADD:
                o_result = i_dataA + i_dataB;
            AluOp_SUB:
                o_result = i_dataA - i_dataB;
            AluOp_SLL:
                o_result = i_dataA << shamt;
            AluOp_SLT:
                o_result = Data'(ltSigned);     // 0 or 1
            AluOp_SLTU:
                o_result = Data'(ltUnsigned);
            AluOp_XOR:
                o_result = i_dataA ^ i_dataB;
            AluOp_SRL:
                o_result = i_dataA >> shamt;    // Zero fill
            AluOp_SRA:
                o_result = Data'($signed(i_dataA) >>> shamt);   // Sign fill
            AluOp_OR:
                o_result = i_dataA | i_dataB;
            AluOp_AND:
                o_result = i_dataA & i_dataB;
            default:
                o_result = '0;                  // Unused codes
        endcase
    end

endmodule

/* rtl/CoreDefs.sv */
`include "exec_settings.svh"

package CoreDefs;

    // --------------------
    // Vector types
    // --------------------
    typedef logic [`DATA_WIDTH-1:0]     Data;       // Integer data word
    typedef logic [`PC_WIDTH-1:0]       InstAddr;   // Instruction address
    typedef logic [31:0]                Inst;       // RV32I instruction word
    typedef logic [4:0]                 RegAddr;    // Register index x0..x31
    typedef logic [`CSR_ADDR_WIDTH-1:0] CSRAddr;    // CSR address

    // --------------------
    // Operation encodings
    // --------------------

    // Operand A source, order matches the selector inputs
    typedef enum logic [1:0] {
        DataASel_RS1,
        DataASel_IMM,
        DataASel_ZERO,
        DataASel_PC
    } DataASel;

    // Operand B source, code 3 unused
    typedef enum logic [1:0] {
        DataBSel_RS2,
        DataBSel_IMM,
        DataBSel_FOUR
    } DataBSel;

    typedef enum logic {
        ResultSel_ALU,
        ResultSel_CSR
    } ResultSel;

    // Integer ALU operations
    typedef enum logic [3:0] {
        AluOp_ADD,
        AluOp_SUB,
        AluOp_SLL,
        AluOp_SLT,
        AluOp_SLTU,
        AluOp_XOR,
        AluOp_SRL,
        AluOp_SRA,
        AluOp_OR,
        AluOp_AND
    } AluOp;

    // CSR read/modify/write kind
    typedef enum logic [1:0] {
        CsrOp_NOP,
        CsrOp_RW,
        CsrOp_RS,
        CsrOp_RC
    } CsrOp;

    // --------------------
    // Packets
    // --------------------

    // Decoder to execute stage
    typedef struct packed {
        Data      imm;          // Selected immediate, already extended
        CSRAddr   csr;          // CSR address field
        RegAddr   rd;           // Destination register, zero when none
        DataASel  aSel;
        DataBSel  bSel;
        ResultSel resultSel;
        AluOp     aluOp;
        CsrOp     csrOp;
    } ExecCtrl;

    // Execute stage to result register
    typedef struct packed {
        Data    dataR;          // Result value
        Data    dataB;          // Store data, rs2 as read
        RegAddr rd;             // Destination register
    } ResultPkt;

endpackage

/* rtl/CsrUnit.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module CsrUnit
    import CoreDefs::*;
(
    input  logic   i_clock,         // Clock
    input  logic   i_rst,           // Synchronous reset
    input  logic   i_evInstRet,     // Instruction retired pulse
    input  logic   i_evMemRead,     // Memory read pulse
    input  logic   i_evMemWrite,    // Memory write pulse
    input  CsrOp   i_op,            // Already gated by valid
    input  CSRAddr i_csr,           // Addressed CSR
    input  Data    i_data,          // Write/set/clear operand
    output Data    o_data);         // Value before the edge

    Data mscratch;
    Data cntInstRet;                // minstret
    Data cntMemRead;                // mhpmcounter3
    Data cntMemWrite;               // mhpmcounter4
    Data mscratchNext;

    // --------------------
    // Read port
    // --------------------
    always_comb begin
        case (i_csr)
            `CSR_MSCRATCH: o_data = mscratch;
            `CSR_MINSTRET: o_data = cntInstRet;
            `CSR_MHPM_RD:  o_data = cntMemRead;
            `CSR_MHPM_WR:  o_data = cntMemWrite;
            default:       o_data = '0;     // Unimplemented reads as zero
        endcase
    end

    // mscratch is the only writable CSR
    always_comb begin
        mscratchNext = mscratch;
        if (i_csr == `CSR_MSCRATCH) begin
            case (i_op)
                CsrOp_RW: mscratchNext = i_data;
                CsrOp_RS: mscratchNext = mscratch | i_data;     // Set bits
                CsrOp_RC: mscratchNext = mscratch & ~i_data;    // Clear bits
                default:  mscratchNext = mscratch;
            endcase
        end
    end

    // --------------------
    // State update
    // --------------------
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            mscratch    <= '0;
            cntInstRet  <= '0;
            cntMemRead  <= '0;
            cntMemWrite <= '0;
        end
        else begin
            mscratch <= mscratchNext;
            // Counters run on events alone, valid or not
            cntInstRet  <= cntInstRet  + Data'(i_evInstRet);
            cntMemRead  <= cntMemRead  + Data'(i_evMemRead);
            cntMemWrite <= cntMemWrite + Data'(i_evMemWrite);
        end
    end

    // First cycle out of reset carries no CSR operation
    assert property (@(posedge i_clock) $fell(i_rst) |-> i_op == CsrOp_NOP)
        else $error("CsrUnit: CSR operation right after reset");

endmodule

/* rtl/ExecCore.sv */
`timescale 1ns/100ps

module ExecCore
    import CoreDefs::*;
(
    input  logic    i_clock,        // Clock
    input  logic    i_rst,          // Synchronous reset
    input  logic    i_valid,        // Instruction present
    input  Inst     i_inst,         // Instruction word
    input  InstAddr i_pc,           // Its address
    input  Data     i_dataRS1,      // X[rs1]
    input  Data     i_dataRS2,      // X[rs2]
    input  logic    i_evInstRet,    // Event pulses for the counters
    input  logic    i_evMemRead,
    input  logic    i_evMemWrite,
    output logic    o_valid,        // Result valid
    output logic    o_illegal,      // Result from an illegal word
    output Data     o_dataR,        // Result value
    output Data     o_dataB,        // Store data
    output RegAddr  o_rd);          // Destination register

    ExecCtrl  ctrl;
    logic     illegal;
    ResultPkt exResult;
    ResultPkt regResult;

    InstDecoder decoder (
        .i_inst    (i_inst),
        .o_ctrl    (ctrl),
        .o_illegal (illegal));

    StageEX stageEx (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_isValid    (i_valid),
        .i_illegal    (illegal),
        .i_ctrl       (ctrl),
        .i_dataRS1    (i_dataRS1),
        .i_dataRS2    (i_dataRS2),
        .i_pc         (i_pc),
        .i_evInstRet  (i_evInstRet),
        .i_evMemRead  (i_evMemRead),
        .i_evMemWrite (i_evMemWrite),
        .o_result     (exResult));

    ResultStage resultStage (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_valid   (i_valid),
        .i_illegal (illegal),
        .i_result  (exResult),
        .o_valid   (o_valid),
        .o_illegal (o_illegal),
        .o_result  (regResult));

    // Split the registered packet
    assign o_dataR = regResult.dataR;
    assign o_dataB = regResult.dataB;
    assign o_rd    = regResult.rd;

endmodule

/* rtl/InstDecoder.sv */
`timescale 1ns/100ps

module InstDecoder
    import CoreDefs::*;
(
    input  Inst     i_inst,     // Instruction word
    output ExecCtrl o_ctrl,     // Control packet for the execute stage
    output logic    o_illegal); // Unsupported encoding

    // Major opcodes
    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcLoad   = 7'b0000011;
    localparam logic [6:0] OpcStore  = 7'b0100011;
    localparam logic [6:0] OpcOpImm  = 7'b0010011;
    localparam logic [6:0] OpcOp     = 7'b0110011;
    localparam logic [6:0] OpcSystem = 7'b1110011;

    // Field extraction
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       altOp;          // Bit 30 where it selects SUB or SRA
    Data        immI, immS, immU, immJ, immZ;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    // --------------------
    // Immediates
    // --------------------
    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign immU = {i_inst[31:12], 12'b0};
    assign immJ = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign immZ = {27'b0, i_inst[19:15]};   // zimm of CSRxxI

    // funct3 to ALU operation, shared by OP and OP-IMM
    function automatic AluOp aluOpOf(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? AluOp_SUB : AluOp_ADD;
            3'b001:  return AluOp_SLL;
            3'b010:  return AluOp_SLT;
            3'b011:  return AluOp_SLTU;
            3'b100:  return AluOp_XOR;
            3'b101:  return alt ? AluOp_SRA : AluOp_SRL;
            3'b110:  return AluOp_OR;
            default: return AluOp_AND;
        endcase
    endfunction

    // OP-IMM only honours bit 30 for the right shift
    assign altOp = (opcode == OpcOp) ? funct7[5] : (funct7[5] && funct3 == 3'b101);

    // --------------------
    // Control decode
    // --------------------
    always_comb begin
        o_ctrl.imm       = immI;                // Most common format
        o_ctrl.csr       = i_inst[31:20];
        o_ctrl.rd        = i_inst[11:7];
        o_ctrl.aSel      = DataASel_RS1;
        o_ctrl.bSel      = DataBSel_IMM;
        o_ctrl.resultSel = ResultSel_ALU;
        o_ctrl.aluOp     = AluOp_ADD;
        o_ctrl.csrOp     = CsrOp_NOP;
        o_illegal        = 1'b0;

        case (opcode)
            OpcLui: begin
                o_ctrl.imm  = immU;
                o_ctrl.aSel = DataASel_ZERO;    // 0 + imm
            end
            OpcAuipc: begin
                o_ctrl.imm  = immU;
                o_ctrl.aSel = DataASel_PC;
            end
            OpcJal, OpcJalr: begin
                o_ctrl.imm  = (opcode == OpcJal) ? immJ : immI;
                o_ctrl.aSel = DataASel_PC;      // Link value PC + 4
                o_ctrl.bSel = DataBSel_FOUR;
                o_illegal   = (opcode == OpcJalr) && (funct3 != 3'b000);
            end
            OpcLoad:                            // Address rs1 + imm
                o_illegal = (funct3 == 3'b011) || (funct3 > 3'b101);
            OpcStore: begin
                o_ctrl.imm = immS;
                o_ctrl.rd  = '0;                // No register written
                o_illegal  = (funct3 > 3'b010);
            end
            OpcOpImm: begin
                o_ctrl.aluOp = aluOpOf(funct3, altOp);
                if (funct3 == 3'b001)
                    o_illegal = (funct7 != 7'b0000000);
                else if (funct3 == 3'b101)
                    o_illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            OpcOp: begin
                o_ctrl.bSel  = DataBSel_RS2;
                o_ctrl.aluOp = aluOpOf(funct3, altOp);
                // Only ADD/SUB and SRL/SRA have an alternate encoding
                o_illegal = (funct7 != 7'b0000000) &&
                            !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OpcSystem: begin
                o_ctrl.resultSel = ResultSel_CSR;
                o_ctrl.imm       = immZ;
                o_ctrl.aSel      = funct3[2] ? DataASel_IMM : DataASel_RS1;
                case (funct3[1:0])
                    2'b01:   o_ctrl.csrOp = CsrOp_RW;
                    2'b10:   o_ctrl.csrOp = CsrOp_RS;
                    2'b11:   o_ctrl.csrOp = CsrOp_RC;
                    default: o_illegal    = 1'b1;   // ECALL, EBREAK and friends
                endcase
            end
            default:
                o_illegal = 1'b1;
        endcase

        // Nothing leaks from an illegal word
        if (o_illegal) begin
            o_ctrl.rd    = '0;
            o_ctrl.csrOp = CsrOp_NOP;
        end
    end

    // Legal packets carry only defined encodings
    always_comb begin
        if (!o_illegal)
            assert (o_ctrl.bSel != 2'b11 && o_ctrl.aluOp inside {AluOp_ADD, AluOp_SUB,
                    AluOp_SLL, AluOp_SLT, AluOp_SLTU, AluOp_XOR, AluOp_SRL, AluOp_SRA,
                    AluOp_OR, AluOp_AND})
                else $error("InstDecoder: undefined select in legal packet");
    end

endmodule

/* rtl/ResultStage.sv */
`timescale 1ns/100ps

module ResultStage
    import CoreDefs::*;
(
    input  logic     i_clock,       // Clock
    input  logic     i_rst,         // Synchronous reset
    input  logic     i_valid,       // Capture enable
    input  logic     i_illegal,     // Illegal flag from the decoder
    input  ResultPkt i_result,      // Packet from the execute stage
    output logic     o_valid,       // One cycle after i_valid
    output logic     o_illegal,
    output ResultPkt o_result);     // Held while idle

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
            o_result  <= '0;        // Output data reads zero after reset
        end
        else begin
            o_valid   <= i_valid;
            o_illegal <= i_valid && i_illegal;  // Flags drop on idle cycles
            if (i_valid)
                o_result <= i_result;
        end
    end

    // An illegal result is valid and reads zero
    assert property (@(posedge i_clock) disable iff (i_rst)
                     o_illegal |-> o_valid && o_result.dataR == '0)
        else $error("ResultStage: illegal result not valid or not zero");

endmodule

/* rtl/StageEX.sv */
`timescale 1ns/100ps

module StageEX
    import CoreDefs::*;
(
    input  logic     i_clock,       // Clock
    input  logic     i_rst,         // Synchronous reset
    input  logic     i_isValid,     // Instruction present this cycle
    input  logic     i_illegal,     // Decoder rejected the word
    input  ExecCtrl  i_ctrl,        // Control packet
    input  Data      i_dataRS1,     // X[rs1]
    input  Data      i_dataRS2,     // X[rs2]
    input  InstAddr  i_pc,          // Instruction address
    input  logic     i_evInstRet,
    input  logic     i_evMemRead,
    input  logic     i_evMemWrite,
    output ResultPkt o_result);     // Result, store data and rd

    Data  operandA;
    Data  operandB;
    Data  aluResult;
    Data  csrResult;
    CsrOp csrOpGated;

    // --------------------
    // Operand selection
    // --------------------
    always_comb begin
        case (i_ctrl.aSel)
            DataASel_RS1:  operandA = i_dataRS1;
            DataASel_IMM:  operandA = i_ctrl.imm;   // Also zimm
            DataASel_ZERO: operandA = '0;           // LUI
            default:       operandA = Data'(i_pc);
        endcase
    end

    always_comb begin
        case (i_ctrl.bSel)
            DataBSel_RS2:  operandB = i_dataRS2;
            DataBSel_IMM:  operandB = i_ctrl.imm;
            DataBSel_FOUR: operandB = Data'(4);     // Link offset
            default:       operandB = '0;
        endcase
    end

    // CSR state only moves for legal, valid instructions
    assign csrOpGated = (i_isValid && !i_illegal) ? i_ctrl.csrOp : CsrOp_NOP;

    Alu aluUnit (
        .i_op     (i_ctrl.aluOp),
        .i_dataA  (operandA),
        .i_dataB  (operandB),
        .o_result (aluResult));

    CsrUnit csrUnit (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_evInstRet  (i_evInstRet),
        .i_evMemRead  (i_evMemRead),
        .i_evMemWrite (i_evMemWrite),
        .i_op         (csrOpGated),
        .i_csr        (i_ctrl.csr),
        .i_data       (operandA),       // rs1 or zimm
        .o_data       (csrResult));

    // --------------------
    // Result selection
    // --------------------
    always_comb begin
        if (i_illegal)
            o_result.dataR = '0;
        else if (i_ctrl.resultSel == ResultSel_CSR)
            o_result.dataR = csrResult;
        else
            o_result.dataR = aluResult;
        o_result.dataB = i_dataRS2;     // Store data
        o_result.rd    = i_ctrl.rd;
    end

endmodule

/* rtl/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// --------------------
// Datapath widths
// --------------------
`define DATA_WIDTH      32          // Integer register width
`define PC_WIDTH        32          // Program counter width
`define CSR_ADDR_WIDTH  12          // CSR address field of SYSTEM instructions

// --------------------
// CSR address map
// --------------------
`define CSR_MSCRATCH    12'h340     // Machine scratch register
`define CSR_MINSTRET    12'hB02     // Instructions retired
`define CSR_MHPM_RD     12'hB03     // mhpmcounter3, memory reads
`define CSR_MHPM_WR     12'hB04     // mhpmcounter4, memory writes

`endif

/* tests/ExecCoreTb.sv */
`timescale 1ns/100ps

module ExecCoreTb
    import CoreDefs::*;
();

    localparam int MaxVectors = 64;
    localparam int ClockPeriod = 100;       // ns

    // One line of the vector file
    typedef struct packed {
        logic    valid;
        Inst     inst;
        InstAddr pc;
        Data     rs1;
        Data     rs2;
        logic    evInstRet;
        logic    evMemRead;
        logic    evMemWrite;
        logic    check;                     // Compare data fields as well
        logic    expValid;
        logic    expIllegal;
        Data     expR;
        Data     expB;
        RegAddr  expRd;
    } TestVec;

    // DUT connections
    logic    i_clock;
    logic    i_rst;
    logic    i_valid;
    Inst     i_inst;
    InstAddr i_pc;
    Data     i_dataRS1;
    Data     i_dataRS2;
    logic    i_evInstRet;
    logic    i_evMemRead;
    logic    i_evMemWrite;
    logic    o_valid;
    logic    o_illegal;
    Data     o_dataR;
    Data     o_dataB;
    RegAddr  o_rd;

    TestVec vectors [MaxVectors];
    string  names [MaxVectors];
    int     vecCount;
    int     passCount;
    int     failCount;
    logic   loadDone;

    ExecCore dut0 (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_dataRS1    (i_dataRS1),
        .i_dataRS2    (i_dataRS2),
        .i_evInstRet  (i_evInstRet),
        .i_evMemRead  (i_evMemRead),
        .i_evMemWrite (i_evMemWrite),
        .o_valid      (o_valid),
        .o_illegal    (o_illegal),
        .o_dataR      (o_dataR),
        .o_dataB      (o_dataB),
        .o_rd         (o_rd));

    initial begin
        i_clock = 1'b0;
        forever #(ClockPeriod / 2) i_clock = ~i_clock;
    end

    // --------------------
    // Vector file
    // --------------------
    task automatic loadVectors();
        int          fd;
        int          fields;
        string       line;
        string       name;
        logic [31:0] col [14];
        TestVec      v;
        fd = $fopen("tests/exec_tests.dat", "r");
        if (fd == 0) begin
            $display("Cannot open tests/exec_tests.dat for reading");
            return;
        end
        while (!$feof(fd) && vecCount < MaxVectors) begin
            line = "";
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() == 0 || line.getc(0) == "#")
                continue;                   // Column notes
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                             col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                             col[7], col[8], col[9], col[10], col[11], col[12], col[13]);
            if (fields <= 0)
                continue;                   // Blank line
            if (fields != 15) begin
                $display("Malformed vector line skipped: %s", line);
                failCount++;
                continue;
            end
            v.valid      = col[0][0];
            v.inst       = col[1];
            v.pc         = col[2];
            v.rs1        = col[3];
            v.rs2        = col[4];
            v.evInstRet  = col[5][0];
            v.evMemRead  = col[6][0];
            v.evMemWrite = col[7][0];
            v.check      = col[8][0];
            v.expValid   = col[9][0];
            v.expIllegal = col[10][0];
            v.expR       = col[11];
            v.expB       = col[12];
            v.expRd      = col[13][4:0];
            names[vecCount]   = name;
            vectors[vecCount] = v;
            vecCount++;
        end
        $fclose(fd);
    endtask

    task automatic applyVector(input TestVec v);
        i_valid      = v.valid;
        i_inst       = v.inst;
        i_pc         = v.pc;
        i_dataRS1    = v.rs1;
        i_dataRS2    = v.rs2;
        i_evInstRet  = v.evInstRet;
        i_evMemRead  = v.evMemRead;
        i_evMemWrite = v.evMemWrite;
    endtask

    // --------------------
    // Output compare
    // --------------------

    // Outputs while reset holds against a busy input
    task automatic checkReset();
        int errs;
        errs = 0;
        if (o_valid !== 1'b0 || o_illegal !== 1'b0) begin
            $display("ERR @ %0d ns: reset o_valid is %b and o_illegal is %b, expected 0",
                     $time, o_valid, o_illegal);
            errs++;
        end
        if (o_dataR !== '0 || o_dataB !== '0 || o_rd !== '0) begin
            $display("ERR @ %0d ns: reset output data is %h %h %0d, expected zero",
                     $time, o_dataR, o_dataB, o_rd);
            errs++;
        end
        if (errs == 0) begin
            passCount++;
            $display("%-14s ok", "reset");
        end
        else begin
            failCount++;
            $display("%-14s FAILED with %0d mismatches", "reset", errs);
        end
    endtask

    task automatic checkVector(input int idx);
        TestVec v;
        int     errs;
        v    = vectors[idx];
        errs = 0;
        if (o_valid !== v.expValid) begin
            $display("ERR @ %0d ns: %s o_valid is %b, expected %b",
                     $time, names[idx], o_valid, v.expValid);
            errs++;
        end
        if (o_illegal !== v.expIllegal) begin
            $display("ERR @ %0d ns: %s o_illegal is %b, expected %b",
                     $time, names[idx], o_illegal, v.expIllegal);
            errs++;
        end
        if (v.check) begin                  // Data only where predictable
            if (o_dataR !== v.expR) begin
                $display("ERR @ %0d ns: %s o_dataR is %h, expected %h",
                         $time, names[idx], o_dataR, v.expR);
                errs++;
            end
            if (o_dataB !== v.expB) begin
                $display("ERR @ %0d ns: %s o_dataB is %h, expected %h",
                         $time, names[idx], o_dataB, v.expB);
                errs++;
            end
            if (o_rd !== v.expRd) begin
                $display("ERR @ %0d ns: %s o_rd is %0d, expected %0d",
                         $time, names[idx], o_rd, v.expRd);
                errs++;
            end
        end
        if (errs == 0) begin
            passCount++;
            $display("%-14s ok", names[idx]);
        end
        else begin
            failCount++;
            $display("%-14s FAILED with %0d mismatches", names[idx], errs);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : stimulus
        i_rst        = 1'b1;
        i_valid      = 1'b1;                // Busy during reset
        i_inst       = 32'hFFFF_FFFF;       // Illegal word
        i_pc         = '0;
        i_dataRS1    = '1;
        i_dataRS2    = '1;                  // Would reach o_dataB without reset
        i_evInstRet  = 1'b0;
        i_evMemRead  = 1'b0;
        i_evMemWrite = 1'b0;
        vecCount     = 0;
        passCount    = 0;
        failCount    = 0;
        loadDone     = 1'b0;
        loadVectors();
        loadDone = 1'b1;
        if (vecCount == 0) begin
            $display("No test vectors could be read, nothing was run");
            $display("Test failures found");
            $finish;
        end
        else begin
            repeat (2) @(posedge i_clock);
            #10;
            checkReset();                       // Reset still asserted here
            i_rst = 1'b0;
            applyVector(vectors[0]);            // Sampled at the next edge
            for (int i = 1; i <= vecCount; i++) begin
                @(posedge i_clock);
                #10;
                checkVector(i - 1);             // Result of the previous line
                if (i < vecCount)
                    applyVector(vectors[i]);
            end
            $display("Tests %0d, passed %0d, failed %0d",
                     passCount + failCount, passCount, failCount);
            if (failCount == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
    end

    // One cycle per vector plus margin for reset
    initial begin : watchdog
        wait (loadDone);
        #((vecCount + 20) * ClockPeriod);
        $display("Timeout, the run did not finish within %0d cycles", vecCount + 20);
        $display("Test failures found");
        $finish;
    end

endmodule

/* tests/exec_tests.dat */
# name valid inst pc rs1 rs2 evInstRet evMemRead evMemWrite check
# expValid expIllegal expResult expStoreData expRd, numbers in hex
reset_idle  0 00000013 00000000 00000000 00000000 0 0 0 1 0 0 00000000 00000000 00
add         1 003100B3 00000000 00001234 00005678 1 0 0 1 1 0 000068AC 00005678 01
sub         1 403100B3 00000000 00000005 00000007 1 1 0 1 1 0 FFFFFFFE 00000007 01
sll         1 00311233 00000000 00000003 00000024 1 0 1 1 1 0 00000030 00000024 04
sra_neg     1 403152B3 00000000 80000000 00000004 0 0 0 1 1 0 F8000000 00000004 05
slt         1 00312333 00000000 FFFFFFFF 00000001 0 0 0 1 1 0 00000001 00000001 06
sltu        1 003133B3 00000000 FFFFFFFF 00000001 0 0 0 1 1 0 00000000 00000001 07
xor         1 00314433 00000000 0F0F0F0F 00FF00FF 0 0 0 1 1 0 0FF00FF0 00FF00FF 08
or          1 003164B3 00000000 0F0F0F0F 00FF00FF 0 0 0 1 1 0 0FFF0FFF 00FF00FF 09
and         1 00317533 00000000 0F0F0F0F 00FF00FF 0 0 0 1 1 0 000F000F 00FF00FF 0A
addi        1 FFF10593 00000000 00000010 DEADBEEF 0 0 0 1 1 0 0000000F DEADBEEF 0B
slti        1 00512613 00000000 FFFFFFFB 00000000 0 0 0 1 1 0 00000001 00000000 0C
sltiu       1 00513693 00000000 FFFFFFFB 00000000 0 0 0 1 1 0 00000000 00000000 0D
xori        1 FFF14713 00000000 12345678 00000000 0 0 0 1 1 0 EDCBA987 00000000 0E
andi        1 0FF17813 00000000 12345678 00000000 0 0 0 1 1 0 00000078 00000000 10
srai        1 40415913 00000000 F0000000 00000000 0 0 0 1 1 0 FF000000 00000000 12
lui         1 12345A37 00000000 FFFFFFFF 00000000 0 0 0 1 1 0 12345000 00000000 14
auipc       1 00001A97 00000100 00000000 00000000 0 0 0 1 1 0 00001100 00000000 15
jal_link    1 008000EF 00000200 00000000 00000000 0 0 0 1 1 0 00000204 00000000 01
sw_addr     1 FE312E23 00000000 00001000 CAFEBABE 0 0 1 1 1 0 00000FFC CAFEBABE 00
csrrw       1 340112F3 00000000 A5A5A5A5 00000000 0 0 0 1 1 0 00000000 00000000 05
csrrs       1 34012373 00000000 0000000F 00000000 0 0 0 1 1 0 A5A5A5A5 00000000 06
csrrc       1 340133F3 00000000 000000A0 00000000 0 0 0 1 1 0 A5A5A5AF 00000000 07
csr_idle    0 340112F3 00000000 FFFFFFFF 00000000 0 0 0 0 0 0 00000000 00000000 00
csr_read    1 34002473 00000000 00000000 00000000 0 0 0 1 1 0 A5A5A50F 00000000 08
csrrwi      1 340FD4F3 00000000 FFFFFFFF 00000000 0 0 0 1 1 0 A5A5A50F 00000000 09
csrrci      1 3401F573 00000000 00000000 00000000 0 0 0 1 1 0 0000001F 00000000 0A
csrrsi_rd   1 340065F3 00000000 00000000 00000000 0 0 0 1 1 0 0000001C 00000000 0B
rd_instret  1 B0202673 00000000 00000000 00000000 0 0 0 1 1 0 00000003 00000000 0C
rd_memread  1 B03026F3 00000000 00000000 00000000 0 0 0 1 1 0 00000001 00000000 0D
wr_memwrite 1 B0411773 00000000 FFFFFFFF 00000000 0 0 0 1 1 0 00000002 00000000 0E
rd_memwrite 1 B04027F3 00000000 00000000 00000000 0 0 0 1 1 0 00000002 00000000 0F
illegal_op  1 FFFFFFFF 00000000 11111111 12345678 0 0 0 1 1 1 00000000 12345678 00
gap         0 00000013 00000000 00000000 00000000 0 0 0 0 0 0 00000000 00000000 00
